//--- filelist.f
+incdir+.
frame_pkg.sv
bw_pkg.sv
frame_timer.sv
marker_retimer.sv
bw_scaler.sv
sym_mrkr_gen.sv
clk_en_gen.sv
sym_timing_top.sv
sym_timing_sva.sv
tb_sym_timing.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_sym_timing
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_sym_timing.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module tb_sym_timing import frame_pkg::*, bw_pkg::*; ();

    localparam int     CLK_PERIOD      = 100;
    localparam int     SLOTS_PER_FRAME = `SLOTS_PER_SUBFRAME * `SUBFRAMES_PER_FRAME;
    localparam longint FRAME_CLKS      = longint'(`SLOT_LEN) * SLOTS_PER_FRAME;
    localparam int     NUM_CFG         = 8;  // four bandwidths, both cp modes
    localparam longint TIMEOUT_NS      = NUM_CFG * 3 * FRAME_CLKS * CLK_PERIOD * 3 / 2;

    logic              clk;
    logic              reset;
    logic              frm_mrkr;
    ch_bw_t            ch_bw;
    cp_mode_t          extended_cp;
    logic              frm_mrkr_out;
    logic              sub_frame_mrkr;
    logic              slot_mrkr;
    logic              sym_mrkr;
    logic              sym_mrkr_pre;
    logic              cp_mrkr;
    logic [4:0]        slot_cnt;
    logic [2:0]        sym_cnt;
    logic [`CNT_W-1:0] sample_cnt_per_slot;
    logic [`CNT_W-1:0] sample_cnt_per_sym;
    logic [`CNT_W-1:0] sample_cnt_4x_per_slot;
    logic [`CNT_W-1:0] sample_cnt_per_sym_4x;
    logic              sym_mrkr_4x;
    logic [2:0]        sym_cnt_4x;
    logic              clk_en;

    int       cur_s;            // decimation shift of the running config
    cp_mode_t cur_cp;
    bit       realign_pending;  // mid-frame strobe issued, boundary checks off
    bit       realign_done;
    bit       frm_sent;         // frm_mrkr issued since the last reset
    bit       upd;              // outputs updated at the last posedge
    bit       running;
    bit       have_sym;
    bit       have_slot;
    bit       en_seen;
    int       en_gap;           // clocks since the last clk_en
    int       c_prev;
    int       sym_prev;
    int       slot_prev;
    int       slot4x_prev;
    int       cnt4x_prev;
    int       pre_prev;
    int       cp_ticks;
    int       marks_4x;
    int       syms_in_slot;
    int       frames_seen;
    int       slots_seen;

    sym_timing_top i_sym_timing_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int shift_for(ch_bw_t bw);
        case (bw)
            bw_10:   return 3;
            bw_5:    return 4;
            default: return 2;  // bw_20, bw_15
        endcase
    endfunction

    function automatic int cp_len_ref(cp_mode_t cp, int sym);
        if (cp == cp_extended)
            return `CP_LEN_EXT;
        return (sym == 0) ? `CP_LEN_FIRST : `CP_LEN_NORMAL;
    endfunction

    function automatic int syms_ref(cp_mode_t cp);
        return (cp == cp_extended) ? `SYMS_EXT : `SYMS_NORMAL;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            fail_run("output value mismatch");
        end
    endtask

    task automatic check_tick();
        int  c;
        int  f;
        int  len;
        int  cp_cnt;
        int  cp_exp;
        bit  skip;
        bit  exp4x;
        c    = int'(sample_cnt_per_sym_4x);
        f    = `SYM_FFT_LEN >> (cur_s + 2);
        skip = realign_pending;
        check_value("sym_mrkr", 32'(sym_mrkr), 32'(pre_prev));  // pre leads by one enable
        pre_prev = int'(sym_mrkr_pre);
        check_value("sample_cnt_per_sym", 32'(sample_cnt_per_sym), 32'(c >> 2));
        check_value("sample_cnt_per_slot", 32'(sample_cnt_per_slot),
                    32'(sample_cnt_4x_per_slot >> 2));
        if (!running && !(frm_sent && frm_mrkr_out)) begin  // idle, nothing may move
            check_value("frm_mrkr_out|sub_frame_mrkr|slot_mrkr|sym_mrkr|cp_mrkr|sym_mrkr_4x",
                        32'({frm_mrkr_out, sub_frame_mrkr, slot_mrkr, sym_mrkr, cp_mrkr,
                             sym_mrkr_4x}), 0);
            check_value("slot_cnt|sym_cnt|sym_cnt_4x", 32'({slot_cnt, sym_cnt, sym_cnt_4x}), 0);
            check_value("sample_cnt_per_sym_4x|sample_cnt_4x_per_slot",
                        {sample_cnt_per_sym_4x, sample_cnt_4x_per_slot}, 0);
            return;
        end
        running = 1;
        check_value("frm_mrkr_out", 32'(frm_mrkr_out), 32'(slot_mrkr && slot_cnt == 5'd0));
        check_value("sub_frame_mrkr", 32'(sub_frame_mrkr), 32'(slot_mrkr && !slot_cnt[0]));
        if (slot_mrkr)
            check_value("sym_mrkr", 32'(sym_mrkr), 1);
        if (sym_mrkr) begin
            check_value("sample_cnt_per_sym_4x", 32'(c), 0);
            if (have_sym && !skip) begin
                len = `SYM_FFT_LEN + cp_len_ref(cur_cp, sym_prev);
                if (c_prev < (len >> cur_s) - 1 || c_prev > ((len - 1) >> cur_s))
                    fail_run($sformatf("last 4x count %0d wrong for symbol length %0d",
                                       c_prev, len));
                cp_cnt = cp_ticks + int'(cp_mrkr);  // this window holds the cp tail
                cp_exp = cp_len_ref(cur_cp, sym_prev) >> cur_s;
                if (cp_cnt < cp_exp || cp_cnt > cp_exp + 2)
                    fail_run($sformatf("cp_mrkr high for %0d enables, expected about %0d",
                                       cp_cnt, cp_exp));
                check_value("sym_mrkr_4x per symbol", 32'(marks_4x), 4);
            end
            if (slot_mrkr) begin
                check_value("sym_cnt", 32'(sym_cnt), 0);
                check_value("sample_cnt_4x_per_slot", 32'(sample_cnt_4x_per_slot), 0);
                if (have_slot && !skip) begin
                    check_value("sym_mrkr per slot", 32'(syms_in_slot), 32'(syms_ref(cur_cp)));
                    check_value("slot_cnt", 32'(slot_cnt), 32'((slot_prev + 1) % SLOTS_PER_FRAME));
                end
                if (frm_mrkr_out) begin
                    frames_seen++;
                    realign_pending = 0;
                end
                syms_in_slot = 0;
                have_slot    = 1;
                slots_seen++;
            end else if (have_sym && !skip) begin
                check_value("sym_cnt", 32'(sym_cnt), 32'(sym_prev + 1));
                check_value("slot_cnt", 32'(slot_cnt), 32'(slot_prev));
            end
            syms_in_slot++;
            have_sym = 1;
            cp_ticks = 0;
            marks_4x = 0;
        end else begin
            check_value("sample_cnt_per_sym_4x", 32'(c), 32'(c_prev + 1));
            check_value("sym_cnt", 32'(sym_cnt), 32'(sym_prev));
            check_value("slot_cnt", 32'(slot_cnt), 32'(slot_prev));
            cp_ticks += int'(cp_mrkr);
        end
        if (!slot_mrkr)
            check_value("sample_cnt_4x_per_slot", 32'(sample_cnt_4x_per_slot),
                        32'(slot4x_prev + 1));
        exp4x = (sym_mrkr && c == 0) || c == f + 1 || c == 2 * f + 2 || c == 3 * f + 3;
        check_value("sym_mrkr_4x", 32'(sym_mrkr_4x), 32'(exp4x));
        if (sym_mrkr_4x) begin
            check_value("sym_cnt_4x", 32'(sym_cnt_4x),
                        slot_mrkr ? 0 : 32'((cnt4x_prev + 1) % 4));
            marks_4x++;
        end else begin
            check_value("sym_cnt_4x", 32'(sym_cnt_4x), 32'(cnt4x_prev));
        end
        c_prev      = c;
        sym_prev    = int'(sym_cnt);
        slot_prev   = int'(slot_cnt);
        slot4x_prev = int'(sample_cnt_4x_per_slot);
        cnt4x_prev  = int'(sym_cnt_4x);
    endtask

    // outputs settle after an enabled posedge, look at them on the next negedge
    initial begin
        upd = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                upd         = 0;
                running     = 0;
                have_sym    = 0;
                have_slot   = 0;
                frm_sent    = 0;
                en_seen     = 0;
                en_gap      = 0;
                pre_prev    = 0;
                cnt4x_prev  = 0;
                frames_seen = 0;
                slots_seen  = 0;
            end else begin
                if (upd)
                    check_tick();
                en_gap++;
                if (clk_en) begin
                    if (en_seen)  // 4, 8 or 16 clocks
                        check_value("clk_en period", 32'(en_gap), 32'(1 << cur_s));
                    en_seen = 1;
                    en_gap  = 0;
                end
                upd = clk_en;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("watchdog expired before all configurations finished");
    end

    task automatic pulse_frm();
        @(negedge clk);
        frm_mrkr = 1'b1;
        frm_sent = 1'b1;
        @(negedge clk);
        frm_mrkr = 1'b0;
    endtask

    task automatic run_config(input ch_bw_t bw, input cp_mode_t cp, input bit realign);
        int base;
        int waited;
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        ch_bw       = bw;
        extended_cp = cp;
        cur_s       = shift_for(bw);
        cur_cp      = cp;
        repeat (7) @(negedge clk);
        reset = 1'b0;
        repeat ($urandom % 1000 + 100) @(negedge clk);  // idle before the strobe
        pulse_frm();
        while (frames_seen < 2)
            @(negedge clk);
        if (realign) begin
            repeat ($urandom % 15000 + 4000) @(negedge clk);
            realign_pending = 1;
            pulse_frm();
            waited = 0;
            while (frames_seen < 3) begin
                @(negedge clk);
                waited++;
                if (waited > 200)
                    fail_run("no frm_mrkr_out after the mid-frame frm_mrkr");
            end
            base = slots_seen;
            while (slots_seen < base + 2)
                @(negedge clk);
            realign_done = 1;
        end
    endtask

    initial begin
        ch_bw_t order [4];
        ch_bw_t tmp;
        int     j;
        void'($urandom(32'hf78a));
        reset           = 1'b1;
        frm_mrkr        = 1'b0;
        ch_bw           = bw_20;
        extended_cp     = cp_normal;
        cur_s           = 2;
        cur_cp          = cp_normal;
        realign_pending = 0;
        realign_done    = 0;
        order = '{bw_20, bw_10, bw_5, bw_15};
        for (int i = 3; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            run_config(order[i], cp_normal, 1'b0);
            run_config(order[i], cp_extended, i == 3);
        end
        if (realign_done) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("mid-frame realignment never completed");
        end
    end

endmodule

//--- sym_timing_sva.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module sym_timing_sva (
    input logic              clk,
    input logic              reset,
    input logic              clk_en,
    input logic              sym_mrkr_pre,
    input logic              sym_mrkr,
    input logic              frm_mrkr_out,
    input logic              slot_mrkr,
    input logic              cp_mrkr,
    input logic              sym_mrkr_4x,
    input logic [4:0]        slot_cnt,
    input logic [2:0]        sym_cnt,
    input logic [2:0]        sym_cnt_4x,
    input logic [`CNT_W-1:0] sample_cnt_per_sym_4x
);

    // marker path and scaler path meet at the symbol start
    pre_leads_sym: assert property (@(posedge clk) disable iff (reset)
        clk_en && sym_mrkr_pre |=> sym_mrkr && (sample_cnt_per_sym_4x == '0))
        else $error("sym_mrkr or zero 4x count missing one enable after sym_mrkr_pre");

    hold_between_en: assert property (@(posedge clk) disable iff (reset)
        !clk_en |=> $stable({frm_mrkr_out, slot_mrkr, sym_mrkr, cp_mrkr, sym_mrkr_4x,
                             slot_cnt, sym_cnt, sym_cnt_4x, sample_cnt_per_sym_4x}))
        else $error("outputs changed without a sample enable");

    cnt_4x_range: assert property (@(posedge clk) disable iff (reset)
        sym_cnt_4x < 3'd4)
        else $error("sym_cnt_4x out of range");

endmodule

bind sym_mrkr_gen sym_timing_sva i_sym_timing_sva (
    .clk                   (clk),
    .reset                 (reset),
    .clk_en                (clk_en),
    .sym_mrkr_pre          (sym_mrkr_pre),
    .sym_mrkr              (sym_mrkr),
    .frm_mrkr_out          (frm_mrkr_out),
    .slot_mrkr             (slot_mrkr),
    .cp_mrkr               (cp_mrkr),
    .sym_mrkr_4x           (sym_mrkr_4x),
    .slot_cnt              (slot_cnt),
    .sym_cnt               (sym_cnt),
    .sym_cnt_4x            (sym_cnt_4x),
    .sample_cnt_per_sym_4x (sample_cnt_per_sym_4x)
);

//--- sym_timing_top.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module sym_timing_top import frame_pkg::*, bw_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              frm_mrkr,
    input  ch_bw_t            ch_bw,
    input  cp_mode_t          extended_cp,
    output logic              frm_mrkr_out,
    output logic              sub_frame_mrkr,
    output logic              slot_mrkr,
    output logic              sym_mrkr,
    output logic              sym_mrkr_pre,
    output logic              cp_mrkr,
    output logic [4:0]        slot_cnt,
    output logic [2:0]        sym_cnt,
    output logic [`CNT_W-1:0] sample_cnt_per_slot,
    output logic [`CNT_W-1:0] sample_cnt_per_sym,
    output logic [`CNT_W-1:0] sample_cnt_4x_per_slot,
    output logic [`CNT_W-1:0] sample_cnt_per_sym_4x,
    output logic              sym_mrkr_4x,
    output logic [2:0]        sym_cnt_4x,
    output logic              clk_en     // sample enable, also for the testbench
);

    clk_en_gen i_clk_en_gen (
        .clk    (clk),
        .reset  (reset),
        .ch_bw  (ch_bw),
        .clk_en (clk_en)
    );

    sym_mrkr_gen i_sym_mrkr_gen (
        .clk                    (clk),
        .reset                  (reset),
        .clk_en                 (clk_en),
        .frm_mrkr               (frm_mrkr),
        .ch_bw                  (ch_bw),
        .extended_cp            (extended_cp),
        .frm_mrkr_out           (frm_mrkr_out),
        .sub_frame_mrkr         (sub_frame_mrkr),
        .slot_mrkr              (slot_mrkr),
        .sym_mrkr               (sym_mrkr),
        .sym_mrkr_pre           (sym_mrkr_pre),
        .cp_mrkr                (cp_mrkr),
        .slot_cnt               (slot_cnt),
        .sym_cnt                (sym_cnt),
        .sample_cnt_per_slot    (sample_cnt_per_slot),
        .sample_cnt_per_sym     (sample_cnt_per_sym),
        .sample_cnt_4x_per_slot (sample_cnt_4x_per_slot),
        .sample_cnt_per_sym_4x  (sample_cnt_per_sym_4x),
        .sym_mrkr_4x            (sym_mrkr_4x),
        .sym_cnt_4x             (sym_cnt_4x)
    );

endmodule

//--- clk_en_gen.sv
`timescale 1ns/1ps

module clk_en_gen import bw_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  ch_bw_t ch_bw,
    output logic   clk_en
);

    logic [4:0] period;  // 4, 8 or 16 clocks
    logic [3:0] cnt;

    assign period = 5'd1 << bw_shift(ch_bw);

    // new bandwidth takes effect at the next reload
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= 4'(period - 5'd1);
            clk_en <= 1'b0;
        end else if (cnt == 4'd0) begin
            cnt    <= 4'(period - 5'd1);
            clk_en <= 1'b1;
        end else begin
            cnt    <= cnt - 4'd1;
            clk_en <= 1'b0;
        end
    end

endmodule

//--- sym_mrkr_gen.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module sym_mrkr_gen import frame_pkg::*, bw_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              clk_en,
    input  logic              frm_mrkr,
    input  ch_bw_t            ch_bw,
    input  cp_mode_t          extended_cp,
    output logic              frm_mrkr_out,
    output logic              sub_frame_mrkr,
    output logic              slot_mrkr,
    output logic              sym_mrkr,
    output logic              sym_mrkr_pre,    // one enable ahead of sym_mrkr
    output logic              cp_mrkr,
    output logic [4:0]        slot_cnt,
    output logic [2:0]        sym_cnt,
    output logic [`CNT_W-1:0] sample_cnt_per_slot,
    output logic [`CNT_W-1:0] sample_cnt_per_sym,
    output logic [`CNT_W-1:0] sample_cnt_4x_per_slot,
    output logic [`CNT_W-1:0] sample_cnt_per_sym_4x,
    output logic              sym_mrkr_4x,
    output logic [2:0]        sym_cnt_4x
);

    frame_mrkr_t fm;      // full rate
    frame_mrkr_t em;      // enable aligned
    frame_mrkr_t em_d;    // matches the scaler register
    scaled_cnt_t cnt;
    logic        mrkr_4x;
    logic [2:0]  cnt_4x;

    frame_timer i_frame_timer (
        .clk         (clk),
        .reset       (reset),
        .frm_mrkr    (frm_mrkr),
        .extended_cp (extended_cp),
        .fm          (fm)
    );

    marker_retimer i_marker_retimer (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .fm     (fm),
        .em     (em)
    );

    bw_scaler i_bw_scaler (
        .clk         (clk),
        .reset       (reset),
        .clk_en      (clk_en),
        .ch_bw       (ch_bw),
        .em          (em),
        .cnt         (cnt),
        .sym_mrkr_4x (mrkr_4x),
        .sym_cnt_4x  (cnt_4x)
    );

    // two enables from em for every output
    always_ff @(posedge clk) begin
        if (reset) begin
            em_d                   <= '0;
            frm_mrkr_out           <= 1'b0;
            sub_frame_mrkr         <= 1'b0;
            slot_mrkr              <= 1'b0;
            sym_mrkr               <= 1'b0;
            cp_mrkr                <= 1'b0;
            slot_cnt               <= 5'd0;
            sym_cnt                <= 3'd0;
            sample_cnt_per_slot    <= '0;
            sample_cnt_per_sym     <= '0;
            sample_cnt_4x_per_slot <= '0;
            sample_cnt_per_sym_4x  <= '0;
            sym_mrkr_4x            <= 1'b0;
            sym_cnt_4x             <= 3'd0;
        end else if (clk_en) begin
            em_d                   <= em;
            frm_mrkr_out           <= em_d.frame;
            sub_frame_mrkr         <= em_d.sub_frame;
            slot_mrkr              <= em_d.slot;
            sym_mrkr               <= em_d.sym;
            cp_mrkr                <= em_d.cp;
            slot_cnt               <= em_d.slot_cnt;
            sym_cnt                <= em_d.sym_cnt;
            sample_cnt_per_slot    <= cnt.sample_cnt_per_slot;
            sample_cnt_per_sym     <= cnt.sample_cnt_per_sym;
            sample_cnt_4x_per_slot <= cnt.sample_cnt_4x_per_slot;
            sample_cnt_per_sym_4x  <= cnt.sample_cnt_per_sym_4x;
            sym_mrkr_4x            <= mrkr_4x;
            sym_cnt_4x             <= cnt_4x;
        end
    end

    assign sym_mrkr_pre = em_d.sym;

endmodule

//--- bw_scaler.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module bw_scaler import frame_pkg::*, bw_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_en,
    input  ch_bw_t      ch_bw,
    input  frame_mrkr_t em,
    output scaled_cnt_t cnt,
    output logic        sym_mrkr_4x,
    output logic [2:0]  sym_cnt_4x
);

    localparam int CW = `CNT_W;

    logic [2:0]    s;        // 4x decimation shift
    logic [CW-1:0] sym_4x;   // 4x sample in symbol
    logic [CW-1:0] slot_4x;  // 4x sample in slot
    logic [CW-1:0] f_len;    // fft length at base rate
    logic [CW-1:0] start_1;
    logic [CW-1:0] start_2;
    logic [CW-1:0] start_3;
    logic          mrkr_4x_nxt;

    assign s       = bw_shift(ch_bw);
    assign sym_4x  = CW'(em.sym_sample) >> s;
    assign slot_4x = CW'(em.slot_sample) >> s;
    assign f_len   = CW'(`SYM_FFT_LEN) >> (s + 3'd2);

    // one sample gap between the four ifft sub-blocks
    assign start_1 = f_len + CW'(1);
    assign start_2 = (f_len << 1) + CW'(2);
    assign start_3 = f_len + (f_len << 1) + CW'(3);

    // count 0 only counts with a symbol strobe, idle counts sit at zero
    assign mrkr_4x_nxt = (em.sym && (sym_4x == '0))
                       || (sym_4x == start_1)
                       || (sym_4x == start_2)
                       || (sym_4x == start_3);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt         <= '0;
            sym_mrkr_4x <= 1'b0;
            sym_cnt_4x  <= 3'd0;
        end else if (clk_en) begin
            cnt.sample_cnt_per_slot    <= slot_4x >> 2;
            cnt.sample_cnt_per_sym     <= sym_4x >> 2;
            cnt.sample_cnt_4x_per_slot <= slot_4x;
            cnt.sample_cnt_per_sym_4x  <= sym_4x;
            sym_mrkr_4x                <= mrkr_4x_nxt;
            if (mrkr_4x_nxt && em.slot)
                sym_cnt_4x <= 3'd0;   // first sub-block of the slot
            else if (mrkr_4x_nxt)
                sym_cnt_4x <= (sym_cnt_4x == 3'd3) ? 3'd0 : sym_cnt_4x + 3'd1;
        end
    end

endmodule

//--- marker_retimer.sv
`timescale 1ns/1ps

module marker_retimer import frame_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_en,
    input  frame_mrkr_t fm,
    output frame_mrkr_t em
);

    logic [4:0] strb_in;  // frame, sub_frame, slot, sym, cp
    logic [4:0] pend;     // events seen since the last enable

    assign strb_in = {fm.frame, fm.sub_frame, fm.slot, fm.sym, fm.cp};

    // strobes between enables stay pending, then last one enable period
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= '0;
            em   <= '0;
        end else if (clk_en) begin
            pend <= '0;
            {em.frame, em.sub_frame, em.slot, em.sym, em.cp} <= pend | strb_in;
            em.slot_cnt    <= fm.slot_cnt;     // counts sampled at the enable
            em.sym_cnt     <= fm.sym_cnt;
            em.slot_sample <= fm.slot_sample;
            em.sym_sample  <= fm.sym_sample;
        end else begin
            pend <= pend | strb_in;
        end
    end

endmodule

//--- frame_timer.sv
`timescale 1ns/1ps
`include "sym_timing_params.svh"

module frame_timer import frame_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        frm_mrkr,     // 10 ms strobe
    input  cp_mode_t    extended_cp,
    output frame_mrkr_t fm
);

    localparam int SYM_LEN_FIRST   = `SYM_FFT_LEN + `CP_LEN_FIRST;
    localparam int SYM_LEN_NORMAL  = `SYM_FFT_LEN + `CP_LEN_NORMAL;
    localparam int SYM_LEN_EXT     = `SYM_FFT_LEN + `CP_LEN_EXT;
    localparam int SLOTS_PER_FRAME = `SLOTS_PER_SUBFRAME * `SUBFRAMES_PER_FRAME;

    timer_state_t            state;
    timer_state_t            state_nxt;
    frame_mrkr_t             fm_nxt;
    logic [SYM_SAMPLE_W-1:0] sym_last;      // last sample of current symbol
    logic [2:0]              sym_cnt_last;  // last symbol of slot
    logic                    sym_end;
    logic                    slot_end;

    // symbol length and symbols per slot follow the cp mode
    always_comb begin
        if (extended_cp == cp_extended) begin
            sym_last     = SYM_SAMPLE_W'(SYM_LEN_EXT - 1);
            sym_cnt_last = 3'(`SYMS_EXT - 1);
        end else begin
            if (fm.sym_cnt == 3'd0)
                sym_last = SYM_SAMPLE_W'(SYM_LEN_FIRST - 1);  // longer cp on symbol 0
            else
                sym_last = SYM_SAMPLE_W'(SYM_LEN_NORMAL - 1);
            sym_cnt_last = 3'(`SYMS_NORMAL - 1);
        end
    end

    // >= so a cp mode change mid symbol still wraps
    assign sym_end  = (fm.sym_sample >= sym_last);
    assign slot_end = sym_end && (fm.sym_cnt >= sym_cnt_last);

    always_comb begin
        fm_nxt    = '0;
        state_nxt = state;
        if (frm_mrkr) begin
            state_nxt = st_run;  // all counts restart at zero
        end else if (state == st_run) begin
            fm_nxt.sym_sample  = sym_end ? '0 : fm.sym_sample + 1'b1;
            fm_nxt.slot_sample = slot_end ? '0 : fm.slot_sample + 1'b1;
            if (slot_end)
                fm_nxt.sym_cnt = 3'd0;
            else if (sym_end)
                fm_nxt.sym_cnt = fm.sym_cnt + 3'd1;
            else
                fm_nxt.sym_cnt = fm.sym_cnt;
            if (!slot_end)
                fm_nxt.slot_cnt = fm.slot_cnt;
            else if (fm.slot_cnt != 5'(SLOTS_PER_FRAME - 1))
                fm_nxt.slot_cnt = fm.slot_cnt + 5'd1;  // last slot wraps to 0
        end

        // markers on the first sample of each unit
        if (state_nxt == st_run) begin
            fm_nxt.sym       = (fm_nxt.sym_sample == '0);
            fm_nxt.slot      = fm_nxt.sym && (fm_nxt.sym_cnt == 3'd0);
            fm_nxt.sub_frame = fm_nxt.slot && (fm_nxt.slot_cnt % `SLOTS_PER_SUBFRAME == 0);
            fm_nxt.frame     = fm_nxt.slot && (fm_nxt.slot_cnt == 5'd0);
            fm_nxt.cp        = (fm_nxt.sym_sample >= SYM_SAMPLE_W'(`SYM_FFT_LEN));  // cp after body
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            fm    <= '0;
        end else begin
            state <= state_nxt;
            fm    <= fm_nxt;
        end
    end

endmodule

//--- bw_pkg.sv
`include "sym_timing_params.svh"

package bw_pkg;

    typedef enum logic [3:0] {
        bw_20 = 4'd0,
        bw_10 = 4'd1,
        bw_5  = 4'd2,
        bw_15 = 4'd3
    } ch_bw_t;

    // enable-rate sample counts
    typedef struct packed {
        logic [`CNT_W-1:0] sample_cnt_per_slot;
        logic [`CNT_W-1:0] sample_cnt_per_sym;
        logic [`CNT_W-1:0] sample_cnt_4x_per_slot;
        logic [`CNT_W-1:0] sample_cnt_per_sym_4x;
    } scaled_cnt_t;

    // log2 of the enable period, also the 4x decimation shift
    function automatic logic [2:0] bw_shift(input ch_bw_t bw);
        case (bw)
            bw_10:   return 3'($clog2(`EN_PER_10));
            bw_5:    return 3'($clog2(`EN_PER_5));
            default: return 3'($clog2(`EN_PER_20));  // bw_20, bw_15, unknown codes
        endcase
    endfunction

endpackage

//--- frame_pkg.sv
`include "sym_timing_params.svh"

package frame_pkg;

    // widest symbol is body plus extended cp
    localparam int SYM_SAMPLE_W  = $clog2(`SYM_FFT_LEN + `CP_LEN_EXT);
    localparam int SLOT_SAMPLE_W = $clog2(`SLOT_LEN);

    typedef enum logic {
        cp_normal   = 1'b0,
        cp_extended = 1'b1
    } cp_mode_t;

    // frame timer waits for the first 10 ms strobe
    typedef enum logic {
        st_idle = 1'b0,
        st_run  = 1'b1
    } timer_state_t;

    // markers and counts, full rate or enable aligned
    typedef struct packed {
        logic                     frame;        // first sample of frame
        logic                     sub_frame;    // first sample of sub-frame
        logic                     slot;         // first sample of slot
        logic                     sym;          // first sample of symbol
        logic                     cp;           // cp samples at symbol end
        logic [4:0]               slot_cnt;     // 0 to 19
        logic [2:0]               sym_cnt;      // symbol in slot
        logic [SLOT_SAMPLE_W-1:0] slot_sample;  // position within slot
        logic [SYM_SAMPLE_W-1:0]  sym_sample;   // position within symbol
    } frame_mrkr_t;

endpackage

//--- sym_timing_params.svh
`ifndef SYM_TIMING_PARAMS_SVH
`define SYM_TIMING_PARAMS_SVH

// frame geometry at the full sample rate, scaled down for simulation
`define SYM_FFT_LEN         256   // symbol body
`define CP_LEN_FIRST        20    // normal cp, symbol 0
`define CP_LEN_NORMAL       18    // normal cp, symbols 1 to 6
`define CP_LEN_EXT          64    // extended cp, every symbol

`define SYMS_NORMAL         7     // symbols per slot, normal cp
`define SYMS_EXT            6     // symbols per slot, extended cp

`define SLOTS_PER_SUBFRAME  2
`define SUBFRAMES_PER_FRAME 10
`define SLOT_LEN            1920  // full-rate samples per slot

// sample enable period in clk cycles per bandwidth
`define EN_PER_20           4     // also used for 15 MHz
`define EN_PER_10           8
`define EN_PER_5            16

`define CNT_W               16    // enable-rate counts

`endif
